// ==== all.f ====
logic/video_pkg.sv
logic/video_timing.sv
logic/video_regs.sv
logic/layer_mixer.sv
logic/palette_ram.sv
logic/video_out.sv
logic/video_top.sv
sim/video_asserts.sv
sim/video_tb.sv

// ==== sim/video_tb.sv ====
// Testbench for the video output path with register, colour, priority and raster tests
`timescale 1ns/1ps

module video_tb;
    import video_pkg::*;

    // Three frames of clocks, one strobe every second clock
    localparam int TIMEOUT = V_TOTAL * H_TOTAL * 2 * 3;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        regs_cs;
    logic        pal_cs;
    logic [10:0] cpu_addr;
    logic [1:0]  dsn;
    cpu_data_t   cpu_dout;
    cpu_data_t   mmr_dout;
    layer_set_t  layers;
    hcount_t     hdump;
    vcount_t     vdump;
    logic        HS;
    logic        VS;
    logic        HB;
    logic        VB;
    logic        LHBL_dly;
    logic        LVBL_dly;
    chan_t       red;
    chan_t       green;
    chan_t       blue;

    logic [31:0] lfsr = 32'h750c_32ee;
    int          cycles = 0;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    cpu_data_t   ctrl_model;
    cpu_data_t   back_model;
    pal_word_t   pal_model [PAL_DEPTH];

    video_top UUT (.*);

    always #50 clk = ~clk;

    // Pixel strobe on every second clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout, run stopped after %0d clocks", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic cpu_data_t lane_merge(input cpu_data_t old_val, input cpu_data_t new_val,
                                             input logic [1:0] lanes);
        cpu_data_t mask;
        mask = {{8{~lanes[1]}}, {8{~lanes[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic pal_index_t layer_index(input layer_set_t lay, input int id);
        return pal_index_t'(id * 512 + int'(lay.pxl[id].colour) * 16 + int'(lay.pxl[id].pen));
    endfunction

    // Front slot first, backdrop when no layer qualifies
    function automatic pal_index_t ref_index(input layer_set_t lay, input cpu_data_t ctrl,
                                             input pal_index_t bd);
        int id;
        for (int s = 3; s >= 0; s--) begin
            id = int'((ctrl >> (6 + 2 * s)) & 16'h3);
            if (ctrl[id] && lay.pxl[id].pen != PEN_CLEAR) begin
                return layer_index(lay, id);
            end
        end
        return bd;
    endfunction

    function automatic int ref_chan(input logic [3:0] c, input logic [3:0] b);
        return (int'(c) * 17 * (int'(b) + 1)) / 16;
    endfunction

    function automatic layer_set_t random_layers();
        layer_set_t lay;
        for (int i = 0; i < 4; i++) begin
            lay.pxl[i].colour = colour_t'(rand_bits(5));
            lay.pxl[i].pen    = pen_t'(rand_bits(4));
            // Keep every layer opaque here
            if (lay.pxl[i].pen == PEN_CLEAR) begin
                lay.pxl[i].pen = 4'd0;
            end
        end
        return lay;
    endfunction

    task automatic check_val(input string test, input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("[FAIL] %s: %s expected %0h got %0h", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string test);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", test);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", test, test_errs);
        end
    endtask

    // Returns on a rising edge where the DUT sees pxl_cen high
    task automatic strobe_edge();
        do begin
            @(posedge clk);
        end while (!pxl_cen);
    endtask

    task automatic cpu_write(input logic to_regs, input logic [10:0] a, input logic [1:0] lanes,
                             input cpu_data_t d);
        @(posedge clk);
        regs_cs  <= to_regs;
        pal_cs   <= !to_regs;
        cpu_addr <= a;
        dsn      <= lanes;
        cpu_dout <= d;
        @(posedge clk);
        regs_cs <= 1'b0;
        pal_cs  <= 1'b0;
        dsn     <= 2'b11;
    endtask

    task automatic reg_write(input reg_addr_t a, input logic [1:0] lanes, input cpu_data_t d);
        cpu_write(1'b1, 11'(a), lanes, d);
        if (a == REG_LAYER_CTRL) begin
            ctrl_model = lane_merge(ctrl_model, d, lanes);
        end else if (a == REG_BACKDROP) begin
            back_model = lane_merge(back_model, d, lanes);
        end
    endtask

    task automatic pal_write(input pal_index_t idx, input pal_word_t w);
        cpu_write(1'b0, idx, 2'b00, w);
        pal_model[idx] = w;
    endtask

    task automatic read_reg(input reg_addr_t a, output cpu_data_t v);
        @(posedge clk);
        cpu_addr <= 11'(a);
        @(negedge clk);
        v = mmr_dout;
    endtask

    // Drive one pixel in the visible area and compare RGB after the pipeline
    task automatic check_pixel(input string test, input layer_set_t lay);
        pal_word_t w;
        w = pal_model[ref_index(lay, ctrl_model, back_model[10:0])];
        do begin
            strobe_edge();
            @(negedge clk);
        end while (!(hdump < H_VISIBLE - 8 && vdump < V_VISIBLE));
        strobe_edge();
        layers <= lay;
        repeat (PIPE_DLY) strobe_edge();
        @(negedge clk);
        assert (LHBL_dly && LVBL_dly) else begin
            $display("[FAIL] %s: checked pixel came out during blanking", test);
            test_errs++;
        end
        check_val(test, "red", ref_chan(w[11:8], w[15:12]), red);
        check_val(test, "green", ref_chan(w[7:4], w[15:12]), green);
        check_val(test, "blue", ref_chan(w[3:0], w[15:12]), blue);
    endtask

    task automatic test_registers();
        cpu_data_t got;
        reg_addr_t a;
        test_errs = 0;
        for (int r = 0; r < 2; r++) begin
            a = (r == 0) ? REG_LAYER_CTRL : REG_BACKDROP;
            for (int l = 0; l < 3; l++) begin
                reg_write(a, 2'(l), cpu_data_t'(rand_bits(16)));
                read_reg(a, got);
                check_val("registers", "readback", (r == 0) ? ctrl_model : back_model, got);
            end
        end
        read_reg(5'h00, got);
        check_val("registers", "unmapped 00", 0, got);
        read_reg(5'h1f, got);
        check_val("registers", "unmapped 1f", 0, got);
        finish_test("registers");
    endtask

    task automatic test_colour();
        layer_set_t lay;
        int         id;
        pal_word_t  w;
        test_errs = 0;
        for (int k = 0; k < 8; k++) begin
            lay = random_layers();
            id  = int'(rand_bits(2));
            w   = (k == 0) ? 16'hffff : pal_word_t'(rand_bits(16));
            // Only the chosen layer is enabled, placed in front
            reg_write(REG_LAYER_CTRL, 2'b00, {2'b00, 2'(id), 6'b0, 2'b00, 4'(1 << id)});
            pal_write(layer_index(lay, id), w);
            check_pixel("colour", lay);
        end
        finish_test("colour");
    endtask

    task automatic test_priority();
        layer_set_t  lay;
        logic [31:0] orders;
        test_errs = 0;
        // Order bytes {front, slot 2, slot 1, back}
        orders = 32'h72_8d_1b_e4;
        for (int o = 0; o < 4; o++) begin
            lay = random_layers();
            for (int id = 0; id < 4; id++) begin
                pal_write(layer_index(lay, id), pal_word_t'(rand_bits(16)));
            end
            reg_write(REG_LAYER_CTRL, 2'b00, {2'b00, orders[8 * o +: 8], 2'b00, 4'hf});
            check_pixel("priority", lay);
        end
        finish_test("priority");
    endtask

    task automatic test_transparency();
        layer_set_t  lay;
        layer_set_t  t;
        logic [27:0] ens;
        logic [27:0] clrs;
        logic [3:0]  clr;
        test_errs = 0;
        ens  = 28'h5_0_3_f_f_f_f;
        clrs = 28'h4_0_0_f_e_c_8;
        // Pen 15 keeps the backdrop entry apart from every opaque layer entry
        reg_write(REG_BACKDROP, 2'b00, {5'b0, 7'(rand_bits(7)), 4'hf});
        pal_write(back_model[10:0], pal_word_t'(rand_bits(16)));
        lay = random_layers();
        for (int id = 0; id < 4; id++) begin
            pal_write(layer_index(lay, id), pal_word_t'(rand_bits(16)));
        end
        for (int c = 0; c < 7; c++) begin
            reg_write(REG_LAYER_CTRL, 2'b00, {2'b00, 8'he4, 2'b00, ens[4 * c +: 4]});
            t   = lay;
            clr = clrs[4 * c +: 4];
            for (int id = 0; id < 4; id++) begin
                if (clr[id]) begin
                    t.pxl[id].pen = PEN_CLEAR;
                end
            end
            check_pixel("transparency", t);
        end
        finish_test("transparency");
    endtask

    // One frame of strobes visits every column and line once
    task automatic test_blanking();
        logic [2:0] hb_d;
        logic [2:0] vb_d;
        int         line_hb;
        int         line_hs;
        logic       line_seen;
        int         vb_lines;
        int         vs_lines;
        hb_d      = '0;
        vb_d      = '0;
        line_hb   = 0;
        line_hs   = 0;
        line_seen = 1'b0;
        vb_lines  = 0;
        vs_lines  = 0;
        test_errs = 0;
        for (int k = 0; k < H_TOTAL * V_TOTAL; k++) begin
            strobe_edge();
            @(negedge clk);
            if (k >= PIPE_DLY) begin
                check_val("blanking", "LHBL_dly", !hb_d[PIPE_DLY - 1], LHBL_dly);
                check_val("blanking", "LVBL_dly", !vb_d[PIPE_DLY - 1], LVBL_dly);
            end
            if (!LHBL_dly || !LVBL_dly) begin
                check_val("blanking", "rgb in blanking", 0, {red, green, blue});
            end
            hb_d = {hb_d[1:0], HB};
            vb_d = {vb_d[1:0], VB};
            if (hdump == 0) begin
                line_hb   = 0;
                line_hs   = 0;
                line_seen = 1'b1;
                if (VB) begin
                    vb_lines++;
                end
                if (VS) begin
                    vs_lines++;
                end
            end
            if (HB) begin
                line_hb++;
            end
            if (HS) begin
                line_hs++;
            end
            if (line_seen && hdump == H_TOTAL - 1) begin
                check_val("blanking", "HB strobes per line", H_TOTAL - H_VISIBLE, line_hb);
                check_val("blanking", "HS strobes per line", HS_END - HS_START, line_hs);
            end
        end
        check_val("blanking", "VB lines", V_TOTAL - V_VISIBLE, vb_lines);
        check_val("blanking", "VS lines", VS_END - VS_START, vs_lines);
        finish_test("blanking");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pxl_cen    = 1'b0;
        regs_cs    = 1'b0;
        pal_cs     = 1'b0;
        cpu_addr   = '0;
        dsn        = 2'b11;
        cpu_dout   = '0;
        layers     = '0;
        ctrl_model = '0;
        back_model = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        for (int i = 0; i < PAL_DEPTH; i++) begin
            pal_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_colour();
        test_priority();
        test_transparency();
        test_blanking();
        $display("summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim/video_asserts.sv ====
// Concurrent checks on raster counter range, blank forcing and sync placement
`timescale 1ns/1ps

module video_asserts (
    input logic               clk,
    input logic               rst,
    input video_pkg::hcount_t hdump,
    input video_pkg::vcount_t vdump,
    input logic               HS,
    input logic               HB,
    input logic               LHBL_dly,
    input logic               LVBL_dly,
    input video_pkg::chan_t   red,
    input video_pkg::chan_t   green,
    input video_pkg::chan_t   blue
);
    import video_pkg::*;

    counts_in_range: assert property (@(posedge clk) disable iff (rst)
        (hdump < H_TOTAL) && (vdump < V_TOTAL))
        else $error("raster count outside the frame");

    // Output must be black whenever either blank is active
    rgb_black_in_blank: assert property (@(posedge clk) disable iff (rst)
        (!LHBL_dly || !LVBL_dly) |-> (red == '0 && green == '0 && blue == '0))
        else $error("RGB not zero during blanking");

    hsync_in_hblank: assert property (@(posedge clk) disable iff (rst) HS |-> HB)
        else $error("HS active outside horizontal blanking");

endmodule

bind video_top video_asserts u_asserts (.*);

// ==== logic/video_top.sv ====
// Video output top level joining timing, registers, mixer, palette and RGB stage
`timescale 1ns/1ps

module video_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  regs_cs,
    input  logic                  pal_cs,
    input  logic [10:0]           cpu_addr,
    input  logic [1:0]            dsn,
    input  video_pkg::cpu_data_t  cpu_dout,
    output video_pkg::cpu_data_t  mmr_dout,
    input  video_pkg::layer_set_t layers,
    output video_pkg::hcount_t    hdump,
    output video_pkg::vcount_t    vdump,
    output logic                  HS,
    output logic                  VS,
    output logic                  HB,
    output logic                  VB,
    output logic                  LHBL_dly,
    output logic                  LVBL_dly,
    output video_pkg::chan_t      red,
    output video_pkg::chan_t      green,
    output video_pkg::chan_t      blue
);
    import video_pkg::*;

    blank_t     blank;
    cpu_data_t  layer_ctrl;
    pal_index_t backdrop;
    mix_word_t  mix;
    pal_wr_t    pal_wr;
    pal_word_t  pal_colour;
    logic       pal_hb;
    logic       pal_vb;

    assign HB = blank.hb;
    assign VB = blank.vb;
    assign HS = blank.hs;
    assign VS = blank.vs;

    // Palette takes full-word writes only
    assign pal_wr.we   = pal_cs && (dsn == 2'b00);
    assign pal_wr.addr = cpu_addr;
    assign pal_wr.data = cpu_dout;

    video_timing u_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .blank(blank)
    );

    video_regs u_regs (
        .clk(clk), .rst(rst), .cs(regs_cs), .addr(cpu_addr[4:0]), .dsn(dsn),
        .din(cpu_dout), .dout(mmr_dout), .layer_ctrl(layer_ctrl), .backdrop(backdrop)
    );

    layer_mixer u_mixer (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .layers(layers),
        .layer_ctrl(layer_ctrl), .backdrop(backdrop), .blank(blank), .mix(mix)
    );

    palette_ram u_pal (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .wr(pal_wr), .mix(mix),
        .colour(pal_colour), .hb(pal_hb), .vb(pal_vb)
    );

    video_out u_out (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .colour(pal_colour),
        .hb(pal_hb), .vb(pal_vb), .red(red), .green(green), .blue(blue),
        .lhbl_dly(LHBL_dly), .lvbl_dly(LVBL_dly)
    );

endmodule

// ==== logic/video_out.sv ====
// Colour output stage scaling palette words to 8-bit RGB with blank forcing
`timescale 1ns/1ps

module video_out (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::pal_word_t colour,
    input  logic                 hb,
    input  logic                 vb,
    output video_pkg::chan_t     red,
    output video_pkg::chan_t     green,
    output video_pkg::chan_t     blue,
    output logic                 lhbl_dly,
    output logic                 lvbl_dly
);
    import video_pkg::*;

    logic blanked;

    // c * 17 * (bright + 1) / 16, full white gives 255
    function automatic chan_t scale(input logic [3:0] c, input logic [3:0] bright);
        logic [11:0] prod;
        prod = 12'(c) * 12'd17 * (12'(bright) + 12'd1);
        return prod[11:4];
    endfunction

    assign blanked = hb || vb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else if (pxl_cen) begin
            if (blanked) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(colour[11:8], colour[15:12]);
                green <= scale(colour[7:4],  colour[15:12]);
                blue  <= scale(colour[3:0],  colour[15:12]);
            end
            // Active-low blanking, aligned with the RGB above
            lhbl_dly <= ~hb;
            lvbl_dly <= ~vb;
        end
    end

endmodule

// ==== logic/palette_ram.sv ====
// Palette memory with a CPU write port and a registered pixel read port
`timescale 1ns/1ps

module palette_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::pal_wr_t   wr,
    input  video_pkg::mix_word_t mix,
    output video_pkg::pal_word_t colour,
    output logic                 hb,
    output logic                 vb
);
    import video_pkg::*;

    pal_word_t mem [PAL_DEPTH];

    // Entries start out black
    initial begin
        for (int i = 0; i < PAL_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // CPU writes land on any clock
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Pixel read, one strobe of latency
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            colour <= mem[mix.idx];
        end
    end

    // Blank flags travel alongside the read data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb <= 1'b0;
            vb <= 1'b0;
        end else if (pxl_cen) begin
            hb <= mix.hb;
            vb <= mix.vb;
        end
    end

endmodule

// ==== logic/layer_mixer.sv ====
// Layer mixer selecting the front-most enabled opaque layer as a palette index
`timescale 1ns/1ps

module layer_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  video_pkg::layer_set_t layers,
    input  video_pkg::cpu_data_t  layer_ctrl,
    input  video_pkg::pal_index_t backdrop,
    input  video_pkg::blank_t     blank,
    output video_pkg::mix_word_t  mix
);
    import video_pkg::*;

    layer_id_t  slot_id [4];
    logic [3:0] slot_hit;
    pal_index_t pick;

    // Order fields, slot 0 at bits 7:6 is the back layer
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            slot_id[i]  = layer_ctrl[6 + 2 * i +: 2];
            slot_hit[i] = layer_ctrl[slot_id[i]] &&
                          (layers.pxl[slot_id[i]].pen != PEN_CLEAR);
        end
    end

    // Front to back, first qualifying slot wins
    always_comb begin
        pick = backdrop;
        if (slot_hit[3]) begin
            pick = {slot_id[3], layers.pxl[slot_id[3]].colour, layers.pxl[slot_id[3]].pen};
        end else if (slot_hit[2]) begin
            pick = {slot_id[2], layers.pxl[slot_id[2]].colour, layers.pxl[slot_id[2]].pen};
        end else if (slot_hit[1]) begin
            pick = {slot_id[1], layers.pxl[slot_id[1]].colour, layers.pxl[slot_id[1]].pen};
        end else if (slot_hit[0]) begin
            pick = {slot_id[0], layers.pxl[slot_id[0]].colour, layers.pxl[slot_id[0]].pen};
        end
    end

    // Index leaves together with the blanking of the same pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix <= '0;
        end else if (pxl_cen) begin
            mix.idx <= pick;
            mix.hb  <= blank.hb;
            mix.vb  <= blank.vb;
        end
    end

endmodule

// ==== logic/video_regs.sv ====
// CPU register bank holding layer control and backdrop with byte-lane writes
`timescale 1ns/1ps

module video_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cs,
    input  video_pkg::reg_addr_t   addr,
    input  logic [1:0]             dsn,
    input  video_pkg::cpu_data_t   din,
    output video_pkg::cpu_data_t   dout,
    output video_pkg::cpu_data_t   layer_ctrl,
    output video_pkg::pal_index_t  backdrop
);
    import video_pkg::*;

    cpu_data_t backdrop_reg;
    logic      wr_en;

    // dsn is active low, bit 1 for the upper byte
    function automatic cpu_data_t byte_merge(
        input cpu_data_t  old_val,
        input cpu_data_t  new_val,
        input logic [1:0] lanes
    );
        cpu_data_t res;
        res = old_val;
        if (!lanes[1]) begin
            res[15:8] = new_val[15:8];
        end
        if (!lanes[0]) begin
            res[7:0] = new_val[7:0];
        end
        return res;
    endfunction

    assign wr_en = cs && (dsn != 2'b11);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl   <= '0;
            backdrop_reg <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_LAYER_CTRL: layer_ctrl   <= byte_merge(layer_ctrl, din, dsn);
                REG_BACKDROP:   backdrop_reg <= byte_merge(backdrop_reg, din, dsn);
                default: ;
            endcase
        end
    end

    // Only the low bits form a palette index
    assign backdrop = backdrop_reg[10:0];

    // Readback, unmapped words read as zero
    always_comb begin
        case (addr)
            REG_LAYER_CTRL: dout = layer_ctrl;
            REG_BACKDROP:   dout = backdrop_reg;
            default:        dout = '0;
        endcase
    end

endmodule

// ==== logic/video_timing.sv ====
// Raster timing generator with pixel and line counters, blanking and sync
`timescale 1ns/1ps

module video_timing (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    output video_pkg::hcount_t hdump,
    output video_pkg::vcount_t vdump,
    output video_pkg::blank_t  blank
);
    import video_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = hdump == hcount_t'(H_TOTAL - 1);
    assign frame_end = vdump == vcount_t'(V_TOTAL - 1);

    // Column counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hdump <= '0;
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Line counter moves once per line wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vdump <= '0;
        end else if (pxl_cen && line_end) begin
            if (frame_end) begin
                vdump <= '0;
            end else begin
                vdump <= vdump + 1'b1;
            end
        end
    end

    // Blanking and sync straight from the counts
    always_comb begin
        blank.hb = hdump >= hcount_t'(H_VISIBLE);
        blank.vb = vdump >= vcount_t'(V_VISIBLE);
        blank.hs = (hdump >= hcount_t'(HS_START)) && (hdump < hcount_t'(HS_END));
        blank.vs = (vdump >= vcount_t'(VS_START)) && (vdump < vcount_t'(VS_END));
    end

endmodule

// ==== logic/video_pkg.sv ====
// Video output package with raster, register map and palette definitions
package video_pkg;

    // Vector types
    typedef logic [8:0]  hcount_t;
    typedef logic [8:0]  vcount_t;
    typedef logic [3:0]  pen_t;
    typedef logic [4:0]  colour_t;
    typedef logic [1:0]  layer_id_t;
    // {layer id, colour, pen}
    typedef logic [10:0] pal_index_t;
    // {brightness, red, green, blue}
    typedef logic [15:0] pal_word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] cpu_data_t;
    typedef logic [7:0]  chan_t;

    // Raster geometry in pixel strobes and lines
    localparam int H_TOTAL   = 512;
    localparam int H_VISIBLE = 384;
    localparam int HS_START  = 400;
    localparam int HS_END    = 432;
    localparam int V_TOTAL   = 262;
    localparam int V_VISIBLE = 224;
    localparam int VS_START  = 234;
    localparam int VS_END    = 237;

    // Strobes from layer input to RGB
    localparam int PIPE_DLY = 3;

    localparam pen_t PEN_CLEAR = 4'd15;
    localparam int   PAL_DEPTH = 2048;

    // Register word addresses
    localparam reg_addr_t REG_LAYER_CTRL = 5'h13;
    localparam reg_addr_t REG_BACKDROP   = 5'h14;

    localparam layer_id_t LAYER_OBJ  = 2'd0;
    localparam layer_id_t LAYER_SCR1 = 2'd1;
    localparam layer_id_t LAYER_SCR2 = 2'd2;
    localparam layer_id_t LAYER_SCR3 = 2'd3;

    typedef struct packed {
        colour_t colour;
        pen_t    pen;
    } layer_pxl_t;

    // One pixel per layer, element n belongs to layer id n
    typedef struct packed {
        layer_pxl_t [3:0] pxl;
    } layer_set_t;

    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } blank_t;

    typedef struct packed {
        pal_index_t idx;
        logic       hb;
        logic       vb;
    } mix_word_t;

    typedef struct packed {
        logic       we;
        pal_index_t addr;
        pal_word_t  data;
    } pal_wr_t;

endpackage
